// File: build.sh
#!/bin/sh
# compile the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module ppfifo_axis_tb -f ppfifo_axis.f -o ppfifo_axis_sim \
  || { echo "build failed"; exit 1; }

out=$(./obj_dir/ppfifo_axis_sim)
echo "$out"

echo "$out" | grep -q "Simulation completed successfully" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// File: hw/frame_distributor.sv
`include "ppfifo_axis_config.svh"
`default_nettype none

module frame_distributor (
  input  wire logic                     i_axi_clk,
  input  wire logic                     rst,
  input  wire ppfifo_axis_pkg::beat_t   i_in,
  input  wire logic                     i_in_valid,
  output logic                          o_in_ready,
  output ppfifo_axis_pkg::beat_t        o_lane_beat,
  output logic [`PPA_LANES-1:0]         o_lane_valid,
  input  wire logic [`PPA_LANES-1:0]    i_lane_ready
);
  import ppfifo_axis_pkg::*;

  localparam logic [`PPA_LANE_BITS-1:0] LAST_LANE = `PPA_LANE_BITS'(`PPA_LANES - 1);

  route_state_e               state;
  logic [`PPA_LANE_BITS-1:0]  sel;
  logic [`PPA_LANE_BITS-1:0]  sel_next;
  logic                       in_fire;

  // ~~~~~~~~~~~~~~~~~~~~
  // steering

  assign o_lane_beat = i_in;                // shared bus, valid picks the lane
  assign o_in_ready  = i_lane_ready[sel];
  assign in_fire     = i_in_valid && o_in_ready;
  assign sel_next    = (sel == LAST_LANE) ? '0 : sel + 1'b1;

  always_comb begin
    o_lane_valid      = '0;
    o_lane_valid[sel] = i_in_valid;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // frame tracking

  always_ff @(posedge i_axi_clk) begin
    if (rst) begin
      state <= ROUTE_IDLE;
      sel   <= '0;
    end
    else begin
      case (state)
        ROUTE_IDLE: begin
          if (in_fire) begin
            if (i_in.last) begin
              sel <= sel_next;          // one beat frame
            end
            else begin
              state <= ROUTE_FRAME;
            end
          end
        end
        ROUTE_FRAME: begin
          // lane stays selected until its last beat is taken
          if (in_fire && i_in.last) begin
            sel   <= sel_next;
            state <= ROUTE_IDLE;
          end
        end
        default: begin
          state <= ROUTE_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/frame_merger.sv
`include "ppfifo_axis_config.svh"
`default_nettype none

module frame_merger (
  input  wire logic                                     i_axi_clk,
  input  wire logic                                     rst,
  input  wire ppfifo_axis_pkg::axis_out_t [`PPA_LANES-1:0] i_lane,
  input  wire logic [`PPA_LANES-1:0]                    i_lane_valid,
  output logic [`PPA_LANES-1:0]                         o_lane_ready,
  output ppfifo_axis_pkg::axis_out_t                    o_out,
  output logic                                          o_out_valid,
  input  wire logic                                     i_out_ready
);
  import ppfifo_axis_pkg::*;

  localparam logic [`PPA_LANE_BITS-1:0] LAST_LANE = `PPA_LANE_BITS'(`PPA_LANES - 1);

  route_state_e               state;
  logic [`PPA_LANE_BITS-1:0]  grant;
  logic [`PPA_LANE_BITS-1:0]  grant_next;
  logic                       out_fire;

  // ~~~~~~~~~~~~~~~~~~~~
  // output mux

  assign o_out       = i_lane[grant];
  assign o_out_valid = i_lane_valid[grant];
  assign out_fire    = o_out_valid && i_out_ready;
  assign grant_next  = (grant == LAST_LANE) ? '0 : grant + 1'b1;

  always_comb begin
    o_lane_ready        = '0;             // others stay frozen
    o_lane_ready[grant] = i_out_ready;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // grant rotation

  always_ff @(posedge i_axi_clk) begin
    if (rst) begin
      state <= ROUTE_IDLE;
      grant <= '0;
    end
    else begin
      case (state)
        ROUTE_IDLE: begin
          if (out_fire) begin
            if (o_out.last) begin
              grant <= grant_next;
            end
            else begin
              state <= ROUTE_FRAME;
            end
          end
        end
        ROUTE_FRAME: begin
          // hold the lane until its frame is out
          if (out_fire && o_out.last) begin
            grant <= grant_next;
            state <= ROUTE_IDLE;
          end
        end
        default: begin
          state <= ROUTE_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/ppfifo_axis_config.svh
`ifndef PPFIFO_AXIS_CONFIG_SVH
`define PPFIFO_AXIS_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~
// datapath

`define PPA_DATA_WIDTH  32

// ~~~~~~~~~~~~~~~~~~~~
// lanes

`define PPA_LANES       4
`define PPA_LANE_BITS   2     // index into PPA_LANES

// ~~~~~~~~~~~~~~~~~~~~
// banks

`define PPA_BANK_DEPTH  16    // also the longest legal frame
`define PPA_SIZE_WIDTH  5     // holds 0..PPA_BANK_DEPTH

`endif

// File: hw/ppfifo_axis_pkg.sv
`include "ppfifo_axis_config.svh"
`default_nettype none

package ppfifo_axis_pkg;

  // input beat, also what the lanes get written with
  typedef struct packed {
    logic [`PPA_DATA_WIDTH-1:0] data;
    logic                       user;
    logic                       last;
  } beat_t;

  typedef struct packed {
    logic [`PPA_DATA_WIDTH-1:0] data;
    logic [3:0]                 user;
    logic                       last;
  } axis_out_t;

  // bank status as the adapter sees it
  typedef struct packed {
    logic                       rdy;
    logic [`PPA_SIZE_WIDTH-1:0] size;
    logic [`PPA_DATA_WIDTH:0]   word;   // user flag on top
  } ppfifo_rd_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_READY,
    RD_RELEASE
  } rd_state_e;

  typedef enum logic {
    WR_FILL,
    WR_WAIT
  } wr_state_e;

  typedef enum logic {
    ROUTE_IDLE,
    ROUTE_FRAME
  } route_state_e;

endpackage

`default_nettype wire

// File: hw/ppfifo_axis_top.sv
`include "ppfifo_axis_config.svh"
`default_nettype none

module ppfifo_axis_top (
  input  wire logic                         i_axi_clk,
  input  wire logic                         rst,
  input  wire ppfifo_axis_pkg::beat_t       i_in,
  input  wire logic                         i_in_valid,
  output logic                              o_in_ready,
  output ppfifo_axis_pkg::axis_out_t        o_out,
  output logic                              o_out_valid,
  input  wire logic                         i_out_ready
);
  import ppfifo_axis_pkg::*;

  beat_t                        lane_beat;
  logic [`PPA_LANES-1:0]        lane_valid;
  logic [`PPA_LANES-1:0]        lane_ready;
  axis_out_t [`PPA_LANES-1:0]   lane_axis;
  logic [`PPA_LANES-1:0]        lane_axis_valid;
  logic [`PPA_LANES-1:0]        lane_axis_ready;

  frame_distributor u_dist (
    .i_axi_clk    (i_axi_clk),
    .rst          (rst),
    .i_in         (i_in),
    .i_in_valid   (i_in_valid),
    .o_in_ready   (o_in_ready),
    .o_lane_beat  (lane_beat),
    .o_lane_valid (lane_valid),
    .i_lane_ready (lane_ready)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // lanes

  for (genvar i = 0; i < `PPA_LANES; i++) begin : g_lane
    ppfifo_lane u_lane (
      .i_axi_clk    (i_axi_clk),
      .rst          (rst),
      .i_wr         (lane_beat),
      .i_wr_valid   (lane_valid[i]),
      .o_wr_ready   (lane_ready[i]),
      .o_axis       (lane_axis[i]),
      .o_axis_valid (lane_axis_valid[i]),
      .i_axis_ready (lane_axis_ready[i])
    );
  end

  frame_merger u_merge (
    .i_axi_clk    (i_axi_clk),
    .rst          (rst),
    .i_lane       (lane_axis),
    .i_lane_valid (lane_axis_valid),
    .o_lane_ready (lane_axis_ready),
    .o_out        (o_out),
    .o_out_valid  (o_out_valid),
    .i_out_ready  (i_out_ready)
  );

endmodule

`default_nettype wire

// File: hw/ppfifo_lane.sv
`include "ppfifo_axis_config.svh"
`default_nettype none

module ppfifo_lane (
  input  wire logic                     i_axi_clk,
  input  wire logic                     rst,
  input  wire ppfifo_axis_pkg::beat_t   i_wr,
  input  wire logic                     i_wr_valid,
  output logic                          o_wr_ready,
  output ppfifo_axis_pkg::axis_out_t    o_axis,
  output logic                          o_axis_valid,
  input  wire logic                     i_axis_ready
);
  import ppfifo_axis_pkg::*;

  localparam int ADDR_W = $clog2(`PPA_BANK_DEPTH);

  logic [`PPA_DATA_WIDTH:0]   mem [2][`PPA_BANK_DEPTH];
  logic [`PPA_SIZE_WIDTH-1:0] bank_size [2];
  logic [1:0]                 bank_rdy;
  wr_state_e                  wr_state;
  logic                       wr_bank;
  logic [`PPA_SIZE_WIDTH-1:0] wr_cnt;
  logic                       wr_fire;
  logic                       rd_bank;
  logic [ADDR_W-1:0]          rd_idx;
  logic                       rd_act;
  logic                       rd_act_q;
  logic                       rd_stb;
  logic                       rd_release;
  ppfifo_rd_t                 rd;

  // ~~~~~~~~~~~~~~~~~~~~
  // write side

  assign o_wr_ready = (wr_state == WR_FILL);
  assign wr_fire    = i_wr_valid && o_wr_ready;

  always_ff @(posedge i_axi_clk) begin
    if (wr_fire) begin
      mem[wr_bank][wr_cnt[ADDR_W-1:0]] <= {i_wr.user, i_wr.data};
      if (i_wr.last) begin
        bank_size[wr_bank] <= wr_cnt + 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // read side

  assign rd_release = rd_act_q && !rd_act;    // adapter let go of the bank

  assign rd.rdy  = bank_rdy[rd_bank];
  assign rd.size = bank_size[rd_bank];
  assign rd.word = mem[rd_bank][rd_idx];

  always_ff @(posedge i_axi_clk) begin
    if (rst) begin
      wr_state <= WR_WAIT;                // ready stays low through reset
      wr_bank  <= 1'b0;
      wr_cnt   <= '0;
      bank_rdy <= '0;
      rd_bank  <= 1'b0;
      rd_idx   <= '0;
      rd_act_q <= 1'b0;
    end
    else begin
      rd_act_q <= rd_act;
      if (rd_stb) begin
        rd_idx <= rd_idx + 1'b1;
      end
      if (rd_release) begin
        bank_rdy[rd_bank] <= 1'b0;
        rd_bank           <= ~rd_bank;
        rd_idx            <= '0;
      end

      case (wr_state)
        WR_FILL: begin
          if (wr_fire) begin
            if (i_wr.last) begin
              bank_rdy[wr_bank] <= 1'b1;  // visible next clock
              wr_bank           <= ~wr_bank;
              wr_cnt            <= '0;
              if (bank_rdy[~wr_bank]) begin
                wr_state <= WR_WAIT;      // other bank still full
              end
            end
            else begin
              wr_cnt <= wr_cnt + 1'b1;
            end
          end
        end
        WR_WAIT: begin
          if (!bank_rdy[wr_bank]) begin
            wr_state <= WR_FILL;
          end
        end
        default: begin
          wr_state <= WR_WAIT;
        end
      endcase
    end
  end

  ppfifo_to_axis u_rd (
    .i_axi_clk    (i_axi_clk),
    .rst          (rst),
    .i_ppfifo     (rd),
    .o_ppfifo_act (rd_act),
    .o_ppfifo_stb (rd_stb),
    .o_axi        (o_axis),
    .o_axi_valid  (o_axis_valid),
    .i_axi_ready  (i_axis_ready)
  );

endmodule

`default_nettype wire

// File: hw/ppfifo_to_axis.sv
`include "ppfifo_axis_config.svh"
`default_nettype none

module ppfifo_to_axis (
  input  wire logic                         i_axi_clk,
  input  wire logic                         rst,
  input  wire ppfifo_axis_pkg::ppfifo_rd_t  i_ppfifo,
  output logic                              o_ppfifo_act,
  output logic                              o_ppfifo_stb,
  output ppfifo_axis_pkg::axis_out_t        o_axi,
  output logic                              o_axi_valid,
  input  wire logic                         i_axi_ready
);
  import ppfifo_axis_pkg::*;

  rd_state_e                  state;
  logic [`PPA_SIZE_WIDTH-1:0] r_count;
  logic                       in_range;
  logic                       final_beat;

  // ~~~~~~~~~~~~~~~~~~~~
  // beat formatting

  assign in_range   = (r_count < i_ppfifo.size);
  assign final_beat = ((r_count + 1'b1) >= i_ppfifo.size);

  assign o_ppfifo_stb = i_axi_ready && o_axi_valid;

  assign o_axi.data    = i_ppfifo.word[`PPA_DATA_WIDTH-1:0];
  assign o_axi.user[0] = i_ppfifo.word[`PPA_DATA_WIDTH];
  assign o_axi.user[3:1] = 3'b000;
  assign o_axi.last    = final_beat && o_ppfifo_act && o_axi_valid;

  // ~~~~~~~~~~~~~~~~~~~~
  // bank handshake

  always_ff @(posedge i_axi_clk) begin
    o_axi_valid <= 1'b0;                  // only READY keeps it up
    if (rst) begin
      state        <= RD_IDLE;
      o_ppfifo_act <= 1'b0;
      r_count      <= '0;
    end
    else begin
      case (state)
        RD_IDLE: begin
          if (i_ppfifo.rdy) begin
            r_count      <= '0;
            o_ppfifo_act <= 1'b1;         // claim the bank
            state        <= RD_READY;
          end
        end
        RD_READY: begin
          if (in_range) begin
            o_axi_valid <= 1'b1;
            if (o_ppfifo_stb) begin
              r_count <= r_count + 1'b1;
              if (final_beat) begin
                o_axi_valid <= 1'b0;
              end
            end
          end
          else begin
            // whole bank sent
            o_ppfifo_act <= 1'b0;
            state        <= RD_RELEASE;
          end
        end
        RD_RELEASE: begin
          state <= RD_IDLE;               // lane frees the bank here
        end
        default: begin
          state <= RD_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: ppfifo_axis.f
+incdir+hw
hw/ppfifo_axis_pkg.sv
hw/frame_distributor.sv
hw/ppfifo_to_axis.sv
hw/ppfifo_lane.sv
hw/frame_merger.sv
hw/ppfifo_axis_top.sv
tests/ppfifo_axis_assertions.sv
tests/ppfifo_axis_tb.sv

// File: tests/ppfifo_axis_assertions.sv
`include "ppfifo_axis_config.svh"
`default_nettype none

module ppfifo_axis_assertions (
  input  wire logic                         i_axi_clk,
  input  wire logic                         rst,
  input  wire ppfifo_axis_pkg::beat_t       i_in,
  input  wire logic                         i_in_valid,
  input  wire logic                         o_in_ready,
  input  wire ppfifo_axis_pkg::axis_out_t   o_out,
  input  wire logic                         o_out_valid,
  input  wire logic                         i_out_ready
);
  import ppfifo_axis_pkg::*;

  logic [`PPA_SIZE_WIDTH-1:0] frame_beats;    // beats already taken in this frame
  logic                       in_fire;

  assign in_fire = i_in_valid && o_in_ready;

  always_ff @(posedge i_axi_clk) begin
    if (rst) begin
      frame_beats <= '0;
    end
    else if (in_fire) begin
      frame_beats <= i_in.last ? '0 : frame_beats + 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // output handshake

  output_held: assert property (@(posedge i_axi_clk) disable iff (rst)
    (o_out_valid && !i_out_ready) |=> (o_out_valid && $stable(o_out)))
    else $error("o_out or o_out_valid changed while i_out_ready was low");

  quiet_after_reset: assert property (@(posedge i_axi_clk)
    rst |=> !o_out_valid)
    else $error("o_out_valid high right after reset");

  // ~~~~~~~~~~~~~~~~~~~~
  // input framing

  frame_fits_bank: assert property (@(posedge i_axi_clk) disable iff (rst)
    in_fire |-> (frame_beats < `PPA_SIZE_WIDTH'(`PPA_BANK_DEPTH)))
    else $error("input frame longer than one bank");

endmodule

`default_nettype wire

// File: tests/ppfifo_axis_tb.sv
`include "ppfifo_axis_config.svh"
`default_nettype none

module ppfifo_axis_tb;
  import ppfifo_axis_pkg::*;

  localparam int NUM_SINGLE   = 4;
  localparam int NUM_WRAP     = 2 * `PPA_LANES + 3;    // wraps the rotation
  localparam int NUM_STALL    = 16;
  localparam int NUM_FILL     = 2 * `PPA_LANES;        // every bank of every lane
  localparam int NUM_FRAMES   = NUM_SINGLE + NUM_WRAP + NUM_STALL + NUM_FILL;
  localparam int READY_ON     = 0;
  localparam int READY_RANDOM = 1;
  localparam int READY_OFF    = 2;

  logic        clk;
  logic        rst;
  beat_t       in_beat;
  logic        in_valid;
  logic        in_ready;
  axis_out_t   out_beat;
  logic        out_valid;
  logic        out_ready;

  beat_t       model_q[$];
  int          frame_len [NUM_FRAMES];
  int          next_frame;
  int          total_beats;
  int          cycle_limit;
  int          cycle_count;
  int          ready_mode;
  logic [31:0] stim_state;
  logic [31:0] stall_state;

  ppfifo_axis_top DUT (
    .i_axi_clk   (clk),
    .rst         (rst),
    .i_in        (in_beat),
    .i_in_valid  (in_valid),
    .o_in_ready  (in_ready),
    .o_out       (out_beat),
    .o_out_valid (out_valid),
    .i_out_ready (out_ready)
  );

  bind ppfifo_axis_top ppfifo_axis_assertions u_assertions (
    .i_axi_clk   (i_axi_clk),
    .rst         (rst),
    .i_in        (i_in),
    .i_in_valid  (i_in_valid),
    .o_in_ready  (o_in_ready),
    .o_out       (o_out),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // helpers

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic end_with_failure();
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic compare_beat(input string name, input axis_out_t exp, input axis_out_t act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected data=%h user=%h last=%b, got data=%h user=%h last=%b",
               $time, name, exp.data, exp.user, exp.last, act.data, act.user, act.last);
      end_with_failure();
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      end_with_failure();
    end
  endtask

  // entered just after a rising edge, returns on the edge that takes the beat
  task automatic wait_accept(input beat_t b);
    @(negedge clk);
    while (!in_ready) begin
      @(negedge clk);
    end
    model_q.push_back(b);
    @(posedge clk);
  endtask

  task automatic send_frame(input int len, input logic gaps);
    beat_t b;
    int    gap;
    for (int i = 0; i < len; i++) begin
      if (gaps) begin
        stim_state = lcg_step(stim_state);
        if (stim_state[31:30] == 2'b00) begin
          gap = int'(stim_state[29]) + 1;
          in_valid <= 1'b0;
          repeat (gap) @(posedge clk);
        end
      end
      stim_state = lcg_step(stim_state);
      b.data = `PPA_DATA_WIDTH'(stim_state);
      stim_state = lcg_step(stim_state);
      b.user = stim_state[31];
      b.last = (i == len - 1);
      in_beat  <= b;
      in_valid <= 1'b1;
      wait_accept(b);
    end
  endtask

  task automatic wait_drain();
    @(posedge clk);
    while (model_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // output side

  initial begin : ready_driver
    out_ready   = 1'b0;
    stall_state = ~32'h180d_06e4;
    forever begin
      @(posedge clk);
      case (ready_mode)
        READY_ON: out_ready <= 1'b1;
        READY_RANDOM: begin
          stall_state = lcg_step(stall_state);
          out_ready <= (stall_state[31:30] != 2'b00);    // stalls about a quarter of cycles
        end
        default: out_ready <= 1'b0;
      endcase
    end
  end

  initial begin : output_monitor
    beat_t     ref_beat;
    axis_out_t exp;
    forever begin
      @(negedge clk);
      if (!rst && out_valid && out_ready) begin
        if (model_q.size() == 0) begin
          $display("output beat at %0t with no input beat left to match it", $time);
          end_with_failure();
        end
        else begin
          ref_beat = model_q.pop_front();
          exp.data = ref_beat.data;
          exp.user = {3'b000, ref_beat.user};
          exp.last = ref_beat.last;
          compare_beat("o_out", exp, out_beat);
        end
      end
    end
  end

  initial begin : watchdog
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count >= cycle_limit) begin
        $display("timeout: output stalled, run still busy after %0d cycles", cycle_count);
        end_with_failure();
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // test sequence

  initial begin : main_seq
    int   sent;
    logic full;
    rst        = 1'b1;
    in_beat    = '0;
    in_valid   = 1'b0;
    ready_mode = READY_OFF;
    stim_state = 32'h180d_06e4;
    next_frame = 0;
    total_beats = 0;
    for (int i = 0; i < NUM_FRAMES; i++) begin
      stim_state = lcg_step(stim_state);
      if (i == 0) frame_len[i] = 1;
      else if (i == 1) frame_len[i] = `PPA_BANK_DEPTH;
      else frame_len[i] = 1 + int'(stim_state[31:16] % `PPA_BANK_DEPTH);
      total_beats += frame_len[i];
    end
    cycle_limit = 4 * total_beats + 200;

    repeat (4) @(posedge clk);
    @(negedge clk);
    compare_bit("o_in_ready", 1'b0, in_ready);
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    compare_bit("o_out_valid", 1'b0, out_valid);
    ready_mode = READY_ON;
    @(posedge clk);

    for (int i = 0; i < NUM_SINGLE; i++) begin    // one frame at a time
      send_frame(frame_len[next_frame], 1'b0);
      next_frame++;
      in_valid <= 1'b0;
      wait_drain();
    end

    for (int i = 0; i < NUM_WRAP; i++) begin      // back to back
      send_frame(frame_len[next_frame], 1'b0);
      next_frame++;
    end
    in_valid <= 1'b0;
    wait_drain();

    @(negedge clk);
    ready_mode = READY_RANDOM;
    @(posedge clk);
    for (int i = 0; i < NUM_STALL; i++) begin
      send_frame(frame_len[next_frame], 1'b1);
      next_frame++;
    end
    in_valid <= 1'b0;
    wait_drain();

    // output held off until every bank is full
    @(negedge clk);
    ready_mode = READY_OFF;
    @(posedge clk);
    sent = 0;
    full = 1'b0;
    while (!full && sent < NUM_FILL) begin
      send_frame(frame_len[next_frame], 1'b0);
      next_frame++;
      sent++;
      in_valid <= 1'b0;
      repeat (2) @(negedge clk);
      full = !in_ready;
      @(posedge clk);
    end
    @(negedge clk);
    compare_bit("o_in_ready", 1'b0, in_ready);
    ready_mode = READY_ON;
    wait_drain();

    repeat (50) @(posedge clk);     // extra beats would hit the monitor
    if (model_q.size() == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end
    else begin
      $display("model queue still holds %0d beats at the end", model_q.size());
      end_with_failure();
    end
  end

endmodule

`default_nettype wire
